// File: flist.f
+incdir+common
common/astro_pkg.sv
logic/game_config.sv
input/key_decoder.sv
input/control_matrix.sv
logic/audio_mixer.sv
logic/cabinet_io.sv
test/cabinet_io_props.sv
test/tb_cabinet_io.sv

// File: test/tb_cabinet_io.sv
`timescale 1ns/1ps
`include "astro_cfg.svh"

module tb_cabinet_io;
	import astro_pkg::*;

	localparam int K_IDLE  = 0;   // Just wait
	localparam int K_DL    = 1;   // Download write
	localparam int K_KEY   = 2;   // Key event, toggle flips
	localparam int K_STILL = 3;   // Key bits change, toggle does not
	localparam int JOY_ITERS = 6;
	localparam int AUD_ITERS = 8;

	logic      clk_sys;
	logic      reset;
	logic      dl_wr;
	byte_t     dl_index;
	addr_t     dl_addr;
	dl_data_t  dl_data;
	key_evt_t  key_evt;
	joy_t      joy_p1;
	joy_t      joy_p2;
	byte_t     col_select;
	logic      speech_busy;
	chip_snd_t chip_l;
	chip_snd_t chip_r;
	pcm_t      sample_l;
	pcm_t      sample_r;
	byte_t     row_data;
	pcm_t      audio_l;
	pcm_t      audio_r;

	// One step table entry per index across the queues
	int    st_test[$];
	int    st_kind[$];
	int    st_a[$];       // Index or scan code
	int    st_b[$];       // Address or pressed
	int    st_c[$];       // Download data
	byte_t st_col[$];
	byte_t st_exp[$];     // Expected row byte

	integer     seed = 32'h9af;
	int         checks = 0;
	int         errors = 0;
	int         test_err_base = 0;
	int         cycles = 0;
	int         cycle_limit;
	logic       toggle;
	game_e      game_m;          // Model state
	byte_t      d2_m;
	byte_t      d3_m;
	logic [4:0] held_p1;         // {fire, right, left, down, up}
	logic [4:0] held_p2;
	int         game_num[4] = '{0, `ASTRO_GAME_SPACEZAP, `ASTRO_GAME_GORF,
	                            `ASTRO_GAME_ROBBY};
	game_e      game_val[4] = '{GAME_NONE, GAME_SPACEZAP, GAME_GORF, GAME_ROBBY};
	byte_t      cols[4] = '{8'h01, 8'h02, 8'h04, 8'h08};
	string      test_name[6] = '{"", "reset idle", "download", "keys", "joysticks",
	                             "audio"};

	cabinet_io dut (.*);

	initial clk_sys = 1'b0;
	always #4 clk_sys = ~clk_sys;   // 8 ns period

	// Run limit
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout: run exceeded %0d cycles", cycle_limit);
			$display("Test failures found");
			$finish;
		end
	end

	task automatic check_value(input logic [15:0] got, input logic [15:0] exp,
	                           input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic report_test(input int num);
		$display("Test %0d (%s) done, %0d errors", num, test_name[num],
		         errors - test_err_base);
		test_err_base = errors;
	endtask

	// Lands 1 ns after the n-th rising edge
	task automatic tick(input int n);
		repeat (n) @(posedge clk_sys);
		#1;
	endtask

	task automatic add_step(input int test, input int kind, input int a, input int b,
	                        input int c, input byte_t col, input byte_t exp);
		st_test.push_back(test);
		st_kind.push_back(kind);
		st_a.push_back(a);
		st_b.push_back(b);
		st_c.push_back(c);
		st_col.push_back(col);
		st_exp.push_back(exp);
	endtask

	task automatic dl_write(input byte_t index, input int addr, input int data);
		dl_wr    = 1'b1;
		dl_index = index;
		dl_addr  = addr_t'(addr);
		dl_data  = dl_data_t'(data);
		tick(1);
		dl_wr = 1'b0;
	endtask

	task automatic key_send(input int code, input int pressed, input bit flip);
		if (flip)
			toggle = ~toggle;
		key_evt = {toggle, pressed[0], code[8:0]};
		tick(1);
	endtask

	task automatic load_game(input int num, input game_e g, input byte_t d2,
	                         input byte_t d3);
		dl_write(`ASTRO_IDX_GAME, 0, num);
		dl_write(`ASTRO_IDX_DIP, 2, d2);
		dl_write(`ASTRO_IDX_DIP, 3, d3);
		tick(3);   // Game decode takes two edges
		game_m = g;
		d2_m   = d2;
		d3_m   = d3;
	endtask

	//==========================================================================
	// Reference model from the cabinet row tables and the mix rules
	//==========================================================================
	function automatic byte_t row_model(input byte_t col, input logic [4:0] p1,
	                                    input logic [4:0] p2, input logic [2:0] cab);
		logic [4:0] p;
		byte_t      stick;
		p     = (col == 8'h02) ? p2 : p1;
		stick = {3'b111, ~p};                          // Fire in bit 4
		if (game_m == GAME_ROBBY)
			stick = {2'b11, ~p[4], 1'b1, ~p[3:0]};     // Fire moves up to bit 5
		if (game_m == GAME_NONE)
			return 8'hFF;
		case (col)
			8'h01: begin   // cab = {coin, start2, start1}
				case (game_m)
					GAME_SPACEZAP:
						return {2'b11, ~cab[1], ~cab[0], d2_m[1], 1'b1, ~cab[2], 1'b1};
					GAME_GORF:
						return {d2_m[2], d2_m[0], ~cab[1], ~cab[0], 1'b1, d2_m[1],
						        ~cab[2], 1'b1};
					default:
						return {1'b0, ~cab[1], ~cab[0], 1'b1, d2_m[1], 1'b1, ~cab[2], 1'b1};
				endcase
			end
			8'h02: return (game_m == GAME_GORF) ? {3'b001, stick[4:0]} : stick;
			8'h04: begin
				if (game_m == GAME_GORF)
					return {speech_busy, 2'b01, stick[4:0]};
				if (game_m == GAME_SPACEZAP)
					return {2'b11, d2_m[0], stick[4:0]};
				return stick;
			end
			8'h08:   return d3_m;
			default: return 8'hFF;
		endcase
	endfunction

	function automatic pcm_t mix_model(input chip_snd_t c, input chip_snd_t c_mono,
	                                   input pcm_t s);
		case (game_m)
			// Speech at a quarter
			GAME_GORF:  return pcm_t'(c) * 128 + pcm_t'(c >> 1) + (s >> 2);
			GAME_ROBBY: return pcm_t'(c) * 257;
			default:    return pcm_t'(c_mono) * 257;                          // Mono
		endcase
	endfunction

	initial begin
		logic [4:0] p1b;
		logic [4:0] p2b;
		dl_wr = 1'b0;
		dl_index = '0;
		dl_addr = '0;
		dl_data = '0;
		toggle = 1'b0;
		key_evt = '0;
		joy_p1 = '0;
		joy_p2 = '0;
		col_select = '0;
		speech_busy = 1'b0;
		chip_l = '0;
		chip_r = '0;
		sample_l = '0;
		sample_r = '0;
		held_p1 = '0;
		held_p2 = '0;
		reset = 1'b1;

		// Nothing loaded
		add_step(1, K_IDLE, 0, 0, 0, 8'h01, 8'hFF);
		add_step(1, K_IDLE, 0, 0, 0, 8'h02, 8'hFF);
		add_step(1, K_IDLE, 0, 0, 0, 8'h04, 8'hFF);
		add_step(1, K_IDLE, 0, 0, 0, 8'h08, 8'hFF);
		// Game and DIP writes with ignored writes in between
		add_step(2, K_DL, `ASTRO_IDX_GAME, 0, 'h0003, 8'h01, 8'hF7);
		add_step(2, K_IDLE, 0, 0, 0, 8'h10, 8'hFF);                    // Unused column
		add_step(2, K_DL, `ASTRO_IDX_DIP, 3, 'h00A5, 8'h08, 8'hA5);
		add_step(2, K_DL, `ASTRO_IDX_DIP, 11, 'h005A, 8'h08, 8'hA5);   // Above the bank
		add_step(2, K_DL, 2, 3, 'h003C, 8'h08, 8'hA5);                 // Foreign index
		add_step(2, K_DL, `ASTRO_IDX_DIP, 2, 'h0001, 8'h04, 8'hFF);
		add_step(2, K_DL, `ASTRO_IDX_GAME, 0, 'h1204, 8'h01, 8'h7B);   // High byte dropped
		add_step(2, K_DL, `ASTRO_IDX_DIP, 2, 'h0006, 8'h01, 8'hBF);
		add_step(2, K_DL, `ASTRO_IDX_GAME, 0, 'h0006, 8'h01, 8'h7F);
		add_step(2, K_DL, `ASTRO_IDX_DIP, 2, 'h0000, 8'h01, 8'h77);
		add_step(2, K_DL, `ASTRO_IDX_GAME, 0, 'h0005, 8'h08, 8'hFF);   // Unknown title
		// Player 1 on Space Zap
		add_step(3, K_DL, `ASTRO_IDX_GAME, 0, 'h0003, 8'h04, 8'hDF);
		add_step(3, K_KEY, 'h075, 1, 0, 8'h04, 8'hDE);
		add_step(3, K_KEY, 'h172, 1, 0, 8'h04, 8'hDC);
		add_step(3, K_KEY, 'h06B, 1, 0, 8'h04, 8'hD8);
		add_step(3, K_KEY, 'h074, 1, 0, 8'h04, 8'hD0);
		add_step(3, K_KEY, 'h014, 1, 0, 8'h04, 8'hC0);
		add_step(3, K_KEY, 'h114, 0, 0, 8'h04, 8'hC0);   // Extended fire does not match
		add_step(3, K_STILL, 'h075, 0, 0, 8'h04, 8'hC0);
		add_step(3, K_KEY, 'h175, 0, 0, 8'h04, 8'hC1);
		add_step(3, K_KEY, 'h072, 0, 0, 8'h04, 8'hC3);
		add_step(3, K_KEY, 'h16B, 0, 0, 8'h04, 8'hC7);
		add_step(3, K_KEY, 'h074, 0, 0, 8'h04, 8'hCF);
		add_step(3, K_KEY, 'h014, 0, 0, 8'h04, 8'hDF);
		// Player 2
		add_step(3, K_KEY, 'h02D, 1, 0, 8'h02, 8'hFE);
		add_step(3, K_KEY, 'h02B, 1, 0, 8'h02, 8'hFC);
		add_step(3, K_KEY, 'h023, 1, 0, 8'h02, 8'hF8);
		add_step(3, K_KEY, 'h034, 1, 0, 8'h02, 8'hF0);
		add_step(3, K_KEY, 'h01C, 1, 0, 8'h02, 8'hE0);
		add_step(3, K_KEY, 'h02D, 0, 0, 8'h02, 8'hE1);
		add_step(3, K_KEY, 'h02B, 0, 0, 8'h02, 8'hE3);
		add_step(3, K_KEY, 'h023, 0, 0, 8'h02, 8'hE7);
		add_step(3, K_KEY, 'h034, 0, 0, 8'h02, 8'hEF);
		add_step(3, K_KEY, 'h01C, 0, 0, 8'h02, 8'hFF);
		// Starts and coin from both sources
		add_step(3, K_KEY, 'h005, 1, 0, 8'h01, 8'hE7);
		add_step(3, K_KEY, 'h016, 1, 0, 8'h01, 8'hE7);
		add_step(3, K_KEY, 'h005, 0, 0, 8'h01, 8'hE7);   // Other source still held
		add_step(3, K_KEY, 'h016, 0, 0, 8'h01, 8'hF7);
		add_step(3, K_KEY, 'h006, 1, 0, 8'h01, 8'hD7);
		add_step(3, K_KEY, 'h006, 0, 0, 8'h01, 8'hF7);
		add_step(3, K_KEY, 'h01E, 1, 0, 8'h01, 8'hD7);
		add_step(3, K_KEY, 'h01E, 0, 0, 8'h01, 8'hF7);
		add_step(3, K_KEY, 'h004, 1, 0, 8'h01, 8'hF5);
		add_step(3, K_KEY, 'h104, 0, 0, 8'h01, 8'hF5);
		add_step(3, K_KEY, 'h004, 0, 0, 8'h01, 8'hF7);
		add_step(3, K_KEY, 'h02E, 1, 0, 8'h01, 8'hF5);
		add_step(3, K_KEY, 'h02E, 0, 0, 8'h01, 8'hF7);

		cycle_limit = 20 * (st_kind.size() + 3 * JOY_ITERS + 4 * AUD_ITERS) + 200;

		repeat (16) @(posedge clk_sys);
		#1 reset = 1'b0;

		// Reset value, before any edge can load the mix
		check_value(audio_l, 16'h0, "audio left after reset");
		check_value(audio_r, 16'h0, "audio right after reset");

		//======================================================================
		// Each table step acts, waits three cycles and checks row and audio
		//======================================================================
		for (int i = 0; i < st_kind.size(); i++) begin
			col_select = st_col[i];
			case (st_kind[i])
				K_DL:    dl_write(byte_t'(st_a[i]), st_b[i], st_c[i]);
				K_KEY:   key_send(st_a[i], st_b[i], 1'b1);
				K_STILL: key_send(st_a[i], st_b[i], 1'b0);
				default: tick(1);
			endcase
			tick(3);
			check_value(row_data, st_exp[i],
			            $sformatf("step %0d column %h row", i, st_col[i]));
			check_value(audio_l, 16'h0, "idle audio left");
			check_value(audio_r, 16'h0, "idle audio right");
			if (i == st_kind.size() - 1 || st_test[i + 1] != st_test[i])
				report_test(st_test[i]);
		end

		// Random sticks over two held keys
		key_send('h075, 1, 1'b1);
		key_send('h023, 1, 1'b1);
		held_p1 = 5'b00001;   // Up
		held_p2 = 5'b00100;   // Left
		for (int g = 1; g < 4; g++) begin
			load_game(game_num[g], game_val[g], $random(seed), $random(seed));
			for (int n = 0; n < JOY_ITERS; n++) begin
				joy_p1      = $random(seed);
				joy_p2      = $random(seed);
				speech_busy = $random(seed);
				p1b = held_p1 | {joy_p1[4], joy_p1[0], joy_p1[1], joy_p1[2], joy_p1[3]};
				p2b = held_p2 | {joy_p2[4], joy_p2[0], joy_p2[1], joy_p2[2], joy_p2[3]};
				foreach (cols[k]) begin
					col_select = cols[k];
					tick(1);
					check_value(row_data, row_model(cols[k], p1b, p2b, joy_p1[8:6]),
					            $sformatf("stick row, column %h", cols[k]));
				end
			end
		end
		report_test(4);

		// Mix per game with equal sides on odd draws
		for (int g = 0; g < 4; g++) begin
			load_game(game_num[g], game_val[g], 8'h00, 8'h00);
			for (int n = 0; n < AUD_ITERS; n++) begin
				chip_l   = $random(seed);
				sample_l = $random(seed);
				chip_r   = $random(seed);
				sample_r = $random(seed);
				if (n % 2 == 1) begin
					chip_r   = chip_l;
					sample_r = sample_l;
				end
				tick(1);
				check_value(audio_l, mix_model(chip_l, chip_l, sample_l), "audio left");
				check_value(audio_r, mix_model(chip_r, chip_l, sample_r), "audio right");
			end
		end
		report_test(5);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// File: test/cabinet_io_props.sv
`timescale 1ns/1ps

// Protocol checks on the top level
module cabinet_io_props (
	input logic                  clk_sys,
	input logic                  reset,
	input astro_pkg::game_e      game,       // Internal decoded game
	input astro_pkg::byte_t      row_data,
	input astro_pkg::chip_snd_t  chip_l,
	input astro_pkg::chip_snd_t  chip_r,
	input astro_pkg::pcm_t       sample_l,
	input astro_pkg::pcm_t       sample_r,
	input astro_pkg::pcm_t       audio_l,
	input astro_pkg::pcm_t       audio_r
);
	import astro_pkg::*;

	// Outputs driven once out of reset
	assert property (@(posedge clk_sys) disable iff (reset)
		!$isunknown({row_data, audio_l, audio_r}))
		else $error("Row or audio output unknown after reset");

	// No title loaded, all switches open
	assert property (@(posedge clk_sys) disable iff (reset)
		game == GAME_NONE |-> row_data == 8'hFF)
		else $error("Row byte not FF with no game loaded");

	// Matching inputs give matching sides a cycle later
	assert property (@(posedge clk_sys) disable iff (reset)
		(chip_l == chip_r && sample_l == sample_r) |=> audio_l == audio_r)
		else $error("Audio sides differ after equal inputs");

endmodule

bind cabinet_io cabinet_io_props u_props (.*);

// File: logic/cabinet_io.sv
`timescale 1ns/1ps
`include "astro_cfg.svh"

// Cabinet inputs and sound mix, top level
module cabinet_io (
	input  logic                  clk_sys,
	input  logic                  reset,
	// Host download
	input  logic                  dl_wr,
	input  astro_pkg::byte_t      dl_index,
	input  astro_pkg::addr_t      dl_addr,
	input  astro_pkg::dl_data_t   dl_data,
	// Player controls
	input  astro_pkg::key_evt_t   key_evt,
	input  astro_pkg::joy_t       joy_p1,
	input  astro_pkg::joy_t       joy_p2,
	// CPU switch matrix
	input  astro_pkg::byte_t      col_select,
	output astro_pkg::byte_t      row_data,
	// Sound
	input  logic                  speech_busy,
	input  astro_pkg::chip_snd_t  chip_l,
	input  astro_pkg::chip_snd_t  chip_r,
	input  astro_pkg::pcm_t       sample_l,
	input  astro_pkg::pcm_t       sample_r,
	output astro_pkg::pcm_t       audio_l,
	output astro_pkg::pcm_t       audio_r
);
	import astro_pkg::*;

	game_e      game;
	byte_t      dip_game_opts;
	byte_t      dip_bank3;
	logic [6:0] keys_p1;
	logic [5:0] keys_p2;

	game_config u_game_config (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.dl_wr         (dl_wr),
		.dl_index      (dl_index),
		.dl_addr       (dl_addr),
		.dl_data       (dl_data),
		.game          (game),
		.dip_game_opts (dip_game_opts),
		.dip_bank3     (dip_bank3)
	);

	key_decoder u_key_decoder (
		.clk_sys (clk_sys),
		.reset   (reset),
		.key_evt (key_evt),
		.keys_p1 (keys_p1),
		.keys_p2 (keys_p2)
	);

	// Combinational path from col_select
	control_matrix u_control_matrix (
		.game          (game),
		.dip_game_opts (dip_game_opts),
		.dip_bank3     (dip_bank3),
		.keys_p1       (keys_p1),
		.keys_p2       (keys_p2),
		.joy_p1        (joy_p1),
		.joy_p2        (joy_p2),
		.speech_busy   (speech_busy),
		.col_select    (col_select),
		.row_data      (row_data)
	);

	audio_mixer u_audio_mixer (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.game     (game),
		.chip_l   (chip_l),
		.chip_r   (chip_r),
		.sample_l (sample_l),
		.sample_r (sample_r),
		.audio_l  (audio_l),
		.audio_r  (audio_r)
	);

endmodule

// File: logic/audio_mixer.sv
`timescale 1ns/1ps
`include "astro_cfg.svh"

// Sound chip plus speech mix, registered
module audio_mixer (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  astro_pkg::game_e      game,
	input  astro_pkg::chip_snd_t  chip_l,
	input  astro_pkg::chip_snd_t  chip_r,
	input  astro_pkg::pcm_t       sample_l,
	input  astro_pkg::pcm_t       sample_r,
	output astro_pkg::pcm_t       audio_l,
	output astro_pkg::pcm_t       audio_r
);
	import astro_pkg::*;

	pcm_t mix_l;
	pcm_t mix_r;

	// Speech is much louder than the chip, so it goes in at a quarter
	always_comb begin
		case (game)
			GAME_GORF: begin
				mix_l = {1'b0, chip_l, chip_l[7:1]} + {2'b00, sample_l[15:2]};
				mix_r = {1'b0, chip_r, chip_r[7:1]} + {2'b00, sample_r[15:2]};
			end
			GAME_ROBBY: begin   // Two chips fitted
				mix_l = {chip_l, chip_l};
				mix_r = {chip_r, chip_r};
			end
			default: begin      // Mono, left chip on both sides
				mix_l = {chip_l, chip_l};
				mix_r = {chip_l, chip_l};
			end
		endcase
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			audio_l <= '0;
			audio_r <= '0;
		end else begin
			audio_l <= mix_l;
			audio_r <= mix_r;
		end
	end

endmodule

// File: input/control_matrix.sv
`timescale 1ns/1ps
`include "astro_cfg.svh"

// Switch matrix: row byte for the column the CPU selects
module control_matrix (
	input  astro_pkg::game_e  game,
	input  astro_pkg::byte_t  dip_game_opts,
	input  astro_pkg::byte_t  dip_bank3,
	input  logic [6:0]        keys_p1,
	input  logic [5:0]        keys_p2,
	input  astro_pkg::joy_t   joy_p1,
	input  astro_pkg::joy_t   joy_p2,
	input  logic              speech_busy,   // Speech still talking, Gorf only
	input  astro_pkg::byte_t  col_select,
	output astro_pkg::byte_t  row_data
);
	import astro_pkg::*;

	// Merged buttons, active high
	logic b1_u, b1_d, b1_l, b1_r, b1_f;
	logic b2_u, b2_d, b2_l, b2_r, b2_f;
	logic b1_s, b2_s, b1_c;
	logic [7:0] d2;             // Short alias for DIP byte 2
	byte_t row_col1;
	byte_t row_col2;
	byte_t row_col4;

	//======================================================================
	// Keys ORed with joystick bits
	//======================================================================
	assign b1_u = keys_p1[`ASTRO_KB_UP]    | joy_p1[3];
	assign b1_d = keys_p1[`ASTRO_KB_DOWN]  | joy_p1[2];
	assign b1_l = keys_p1[`ASTRO_KB_LEFT]  | joy_p1[1];
	assign b1_r = keys_p1[`ASTRO_KB_RIGHT] | joy_p1[0];
	assign b1_f = keys_p1[`ASTRO_KB_FIRE]  | joy_p1[4];

	assign b2_u = keys_p2[`ASTRO_KB_UP]    | joy_p2[3];
	assign b2_d = keys_p2[`ASTRO_KB_DOWN]  | joy_p2[2];
	assign b2_l = keys_p2[`ASTRO_KB_LEFT]  | joy_p2[1];
	assign b2_r = keys_p2[`ASTRO_KB_RIGHT] | joy_p2[0];
	assign b2_f = keys_p2[`ASTRO_KB_FIRE]  | joy_p2[4];

	// Cabinet buttons all live on the player 1 stick
	assign b1_s = keys_p1[`ASTRO_KB_START] | joy_p1[6];
	assign b2_s = keys_p2[`ASTRO_KB_START] | joy_p1[7];   // Start 2 key sits in p2 vector
	assign b1_c = keys_p1[`ASTRO_KB_COIN]  | joy_p1[8];

	assign d2 = dip_game_opts;

	//======================================================================
	// Per game rows, switches read active low
	//======================================================================
	always_comb begin
		// Column 01: coin, starts and game DIPs
		case (game)
			GAME_SPACEZAP: row_col1 = {2'b11, ~b2_s, ~b1_s, d2[1], 1'b1, ~b1_c, 1'b1};
			GAME_GORF:     row_col1 = {d2[2], d2[0], ~b2_s, ~b1_s, 1'b1, d2[1], ~b1_c, 1'b1};
			GAME_ROBBY:    row_col1 = {1'b0, ~b2_s, ~b1_s, 1'b1, d2[1], 1'b1, ~b1_c, 1'b1};
			default:       row_col1 = 8'hFF;
		endcase

		// Column 02: player 2 stick
		case (game)
			GAME_SPACEZAP: row_col2 = {3'b111, ~b2_f, ~b2_r, ~b2_l, ~b2_d, ~b2_u};
			GAME_GORF:     row_col2 = {3'b001, ~b2_f, ~b2_r, ~b2_l, ~b2_d, ~b2_u};
			GAME_ROBBY:    row_col2 = {2'b11, ~b2_f, 1'b1, ~b2_r, ~b2_l, ~b2_d, ~b2_u};
			default:       row_col2 = 8'hFF;
		endcase

		// Column 04: player 1 stick, plus speech status on Gorf
		case (game)
			GAME_SPACEZAP: row_col4 = {2'b11, d2[0], ~b1_f, ~b1_r, ~b1_l, ~b1_d, ~b1_u};
			GAME_GORF:     row_col4 = {speech_busy, 2'b01, ~b1_f, ~b1_r, ~b1_l, ~b1_d, ~b1_u};
			GAME_ROBBY:    row_col4 = {2'b11, ~b1_f, 1'b1, ~b1_r, ~b1_l, ~b1_d, ~b1_u};
			default:       row_col4 = 8'hFF;
		endcase
	end

	//======================================================================
	// Column select
	//======================================================================
	always_comb begin
		if (game == GAME_NONE) begin
			row_data = 8'hFF;   // Nothing loaded, all open
		end else begin
			case (col_select)
				8'h01:   row_data = row_col1;
				8'h02:   row_data = row_col2;
				8'h04:   row_data = row_col4;
				8'h08:   row_data = dip_bank3;   // Same DIP row on every title
				default: row_data = 8'hFF;       // Unused or multiple columns
			endcase
		end
	end

endmodule

// File: input/key_decoder.sv
`timescale 1ns/1ps
`include "astro_cfg.svh"

// Keyboard events to held button state for both players
module key_decoder (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  astro_pkg::key_evt_t  key_evt,
	output logic [6:0]           keys_p1,   // up down left right fire start coin
	output logic [5:0]           keys_p2    // up down left right fire start(2)
);
	import astro_pkg::*;

	logic  toggle_q;     // Toggle bit seen last cycle
	logic  evt_take;
	logic  pressed;
	logic  ext;
	byte_t code;

	// Player 1
	logic up1, down1, left1, right1, fire1;
	// Start and coin, one flag per key
	logic start1_a, start1_b;
	logic start2_a, start2_b;
	logic coin_a, coin_b;
	// Player 2
	logic up2, down2, left2, right2, fire2;

	assign evt_take = key_evt[10] != toggle_q;   // New event on any toggle change
	assign pressed  = key_evt[9];
	assign ext      = key_evt[8];                // Extended prefix
	assign code     = key_evt[7:0];

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			toggle_q <= 1'b0;
			{up1, down1, left1, right1, fire1} <= '0;
			{start1_a, start1_b, start2_a, start2_b} <= '0;
			{coin_a, coin_b} <= '0;
			{up2, down2, left2, right2, fire2} <= '0;
		end else begin
			toggle_q <= key_evt[10];
			if (evt_take) begin
				case (code)
					// Arrows ignore the extended bit
					`ASTRO_KEY_UP:    up1    <= pressed;
					`ASTRO_KEY_DOWN:  down1  <= pressed;
					`ASTRO_KEY_LEFT:  left1  <= pressed;
					`ASTRO_KEY_RIGHT: right1 <= pressed;
					// Everything else is a plain code
					`ASTRO_KEY_FIRE1:      if (!ext) fire1    <= pressed;
					`ASTRO_KEY_START1:     if (!ext) start1_a <= pressed;
					`ASTRO_KEY_START1_ALT: if (!ext) start1_b <= pressed;
					`ASTRO_KEY_START2:     if (!ext) start2_a <= pressed;
					`ASTRO_KEY_START2_ALT: if (!ext) start2_b <= pressed;
					`ASTRO_KEY_COIN:       if (!ext) coin_a   <= pressed;
					`ASTRO_KEY_COIN_ALT:   if (!ext) coin_b   <= pressed;
					`ASTRO_KEY_UP2:        if (!ext) up2      <= pressed;
					`ASTRO_KEY_DOWN2:      if (!ext) down2    <= pressed;
					`ASTRO_KEY_LEFT2:      if (!ext) left2    <= pressed;
					`ASTRO_KEY_RIGHT2:     if (!ext) right2   <= pressed;
					`ASTRO_KEY_FIRE2:      if (!ext) fire2    <= pressed;
					default: ;   // Unmapped key
				endcase
			end
		end
	end

	// Player 1 vector
	assign keys_p1[`ASTRO_KB_UP]    = up1;
	assign keys_p1[`ASTRO_KB_DOWN]  = down1;
	assign keys_p1[`ASTRO_KB_LEFT]  = left1;
	assign keys_p1[`ASTRO_KB_RIGHT] = right1;
	assign keys_p1[`ASTRO_KB_FIRE]  = fire1;
	assign keys_p1[`ASTRO_KB_START] = start1_a | start1_b;   // F1 or 1
	assign keys_p1[`ASTRO_KB_COIN]  = coin_a | coin_b;       // F3 or 5

	// Player 2 vector, start slot carries start 2
	assign keys_p2[`ASTRO_KB_UP]    = up2;
	assign keys_p2[`ASTRO_KB_DOWN]  = down2;
	assign keys_p2[`ASTRO_KB_LEFT]  = left2;
	assign keys_p2[`ASTRO_KB_RIGHT] = right2;
	assign keys_p2[`ASTRO_KB_FIRE]  = fire2;
	assign keys_p2[`ASTRO_KB_START] = start2_a | start2_b;   // F2 or 2

endmodule

// File: logic/game_config.sv
`timescale 1ns/1ps
`include "astro_cfg.svh"

// Holds game number and DIP bank written by the host download port
module game_config (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               dl_wr,
	input  astro_pkg::byte_t   dl_index,
	input  astro_pkg::addr_t   dl_addr,
	input  astro_pkg::dl_data_t dl_data,
	output astro_pkg::game_e   game,
	output astro_pkg::byte_t   dip_game_opts,   // DIP byte 2
	output astro_pkg::byte_t   dip_bank3        // DIP byte 3
);
	import astro_pkg::*;

	byte_t game_num;                          // Raw number from host
	byte_t dip_bank [`ASTRO_DIP_BYTES];       // Eight DIP switch bytes
	logic  game_wr;
	logic  dip_wr;

	// Write qualifiers
	assign game_wr = dl_wr && (dl_index == `ASTRO_IDX_GAME);
	assign dip_wr  = dl_wr && (dl_index == `ASTRO_IDX_DIP) &&
	                 (dl_addr < addr_t'(`ASTRO_DIP_BYTES));   // Addr 8 and up dropped

	//======================================================================
	// Stage 1: capture
	//======================================================================
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			game_num <= '0;
		end else if (game_wr) begin
			game_num <= dl_data[7:0];   // Low byte only
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < `ASTRO_DIP_BYTES; i++) begin
				dip_bank[i] <= '0;   // All switches off
			end
		end else if (dip_wr) begin
			dip_bank[dl_addr[2:0]] <= dl_data[7:0];
		end
	end

	//======================================================================
	// Stage 2: decode number into game
	//======================================================================
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			game <= GAME_NONE;
		end else begin
			case (game_num)
				`ASTRO_GAME_SPACEZAP: game <= GAME_SPACEZAP;
				`ASTRO_GAME_GORF:     game <= GAME_GORF;
				`ASTRO_GAME_ROBBY:    game <= GAME_ROBBY;
				default:              game <= GAME_NONE;   // Unsupported titles
			endcase
		end
	end

	// Only these two bytes are read by the switch matrix
	assign dip_game_opts = dip_bank[2];
	assign dip_bank3     = dip_bank[3];

endmodule

// File: common/astro_pkg.sv
`include "astro_cfg.svh"

package astro_pkg;

	//======================================================================
	// Data widths
	//======================================================================

	// Generic byte: DIP byte, switch column select, switch row
	typedef logic [7:0] byte_t;

	// Host download port
	typedef logic [`ASTRO_ADDR_W-1:0] addr_t;
	typedef logic [15:0]              dl_data_t;

	// Digital joystick word
	// 0 right, 1 left, 2 down, 3 up, 4 fire, 6 start 1, 7 start 2, 8 coin
	typedef logic [15:0] joy_t;

	// Keyboard event
	// [10] toggle, [9] pressed, [8] extended, [7:0] code
	typedef logic [10:0] key_evt_t;

	// Audio
	typedef logic [7:0]  chip_snd_t;   // Sound chip output, unsigned
	typedef logic [15:0] pcm_t;        // Speech sample or mixed output

	//======================================================================
	// Game selection
	//======================================================================

	// Only the three supported cabinets; anything else is NONE
	typedef enum logic [1:0] {
		GAME_NONE,
		GAME_SPACEZAP,
		GAME_GORF,
		GAME_ROBBY
	} game_e;

endpackage

// File: common/astro_cfg.svh
`ifndef ASTRO_CFG_SVH
`define ASTRO_CFG_SVH

//==========================================================================
// Download port
//==========================================================================
`define ASTRO_ADDR_W       25         // Host download address width
`define ASTRO_IDX_GAME     8'd1       // Game number write
`define ASTRO_IDX_DIP      8'd254     // DIP switch bank write
`define ASTRO_DIP_BYTES    8

// Game numbers as sent by the host
`define ASTRO_GAME_SPACEZAP 8'd3
`define ASTRO_GAME_GORF     8'd4
`define ASTRO_GAME_ROBBY    8'd6

//==========================================================================
// Keyboard scan codes, low 8 bits
//==========================================================================
`define ASTRO_KEY_UP          8'h75   // Arrows, extended or not
`define ASTRO_KEY_DOWN        8'h72
`define ASTRO_KEY_LEFT        8'h6B
`define ASTRO_KEY_RIGHT       8'h74
`define ASTRO_KEY_FIRE1       8'h14   // Ctrl
`define ASTRO_KEY_START1      8'h05   // F1
`define ASTRO_KEY_START1_ALT  8'h16   // 1
`define ASTRO_KEY_START2      8'h06   // F2
`define ASTRO_KEY_START2_ALT  8'h1E   // 2
`define ASTRO_KEY_COIN        8'h04   // F3
`define ASTRO_KEY_COIN_ALT    8'h2E   // 5
`define ASTRO_KEY_UP2         8'h2D   // R
`define ASTRO_KEY_DOWN2       8'h2B   // F
`define ASTRO_KEY_LEFT2       8'h23   // D
`define ASTRO_KEY_RIGHT2      8'h34   // G
`define ASTRO_KEY_FIRE2       8'h1C   // A

// Bit positions in the held key vectors
`define ASTRO_KB_UP     0
`define ASTRO_KB_DOWN   1
`define ASTRO_KB_LEFT   2
`define ASTRO_KB_RIGHT  3
`define ASTRO_KB_FIRE   4
`define ASTRO_KB_START  5
`define ASTRO_KB_COIN   6     // Player 1 only

`endif
